// ==== common/progress_config.svh ====
// Progress controller configuration
// Bus width, byte lanes and the address region codes of the serial core

`ifndef PROGRESS_CONFIG_SVH
`define PROGRESS_CONFIG_SVH

// Address and data bus width
`define PC_ADDR_W 32

// One select per byte of the 32-bit bus
`define PC_LANES 4

// Top-nibble region codes
`define PC_REGION_IO   4'h4 // Peripheral registers
`define PC_REGION_CTRL 4'h2 // Control registers in block RAM space

// Any address with this bit set is SRAM
`define PC_REGION_SRAM_BIT 31

`endif

// ==== common/bus_pkg.sv ====
// Bus package
// Byte-lane and address region types, region decode and store alignment check

`include "progress_config.svh"

package bus_pkg;

   typedef logic [`PC_LANES-1:0] sel_t; // One bit per byte lane

   // Region of an access, taken from the top address bits
   typedef enum logic [1:0] {
      REGION_SRAM = 2'd0,
      REGION_IO   = 2'd1,
      REGION_CTRL = 2'd2,
      REGION_NONE = 2'd3
   } region_t;

   // SRAM bit wins over the nibble codes
   function automatic region_t addr_region(input logic [`PC_ADDR_W-1:0] addr);
      logic [3:0] nibble;
      nibble = addr[`PC_ADDR_W-1 -: 4];
      if (addr[`PC_REGION_SRAM_BIT])
         return REGION_SRAM;
      else if (nibble == `PC_REGION_IO)
         return REGION_IO;
      else if (nibble == `PC_REGION_CTRL)
         return REGION_CTRL;
      else
         return REGION_NONE;
   endfunction

   // SW must hit a word boundary, other stores are never refused here
   function automatic logic store_misaligned(input logic word_store,
                                             input logic [`PC_ADDR_W-1:0] addr);
      return word_store & (addr[1] | addr[0]);
   endfunction

endpackage

// ==== common/ucode_pkg.sv ====
// Microcode package
// Access size as encoded on the block RAM write-address mux bits

package ucode_pkg;

   typedef enum logic [1:0] {
      ACC_WORD = 2'd0,
      ACC_HALF = 2'd1,
      ACC_BYTE = 2'd2
   } access_t;

   // Mux bits in order sa27, sa26, sa25, sa24
   function automatic access_t decode_access(input logic [3:0] wmux);
      access_t acc;
      case (wmux)
         4'b0001: acc = ACC_HALF;
         4'b0010: acc = ACC_BYTE;
         default: acc = ACC_WORD; // All remaining codes move full words
      endcase
      return acc;
   endfunction

endpackage

// ==== source/byte_select.sv ====
// Byte select register
// Picks the active byte lanes from the access size and the low address bits,
// and keeps an active-low copy for the block RAM write mask

`timescale 1ns/1ps

module byte_select
   import bus_pkg::*, ucode_pkg::*;
(
   input  logic       clk,
   input  logic       RST_I,
   input  logic       sa41,    // Load the selects
   input  logic       sa27,
   input  logic       sa26,
   input  logic       sa25,
   input  logic       sa24,
   input  logic [1:0] addr_lo, // Byte offset in the word
   output sel_t       sel,
   output sel_t       bmask
);

   access_t access; // Size of the coming access
   sel_t    lanes;  // Lanes before the register

   assign access = decode_access({sa27, sa26, sa25, sa24});

   always_comb begin
      case (access)
         ACC_HALF: begin
            case (addr_lo)
               2'b00:   lanes = 4'b0011; // Lower halfword
               2'b10:   lanes = 4'b1100; // Upper halfword
               default: lanes = '1;      // Odd halfword falls back to the full word
            endcase
         end
         ACC_BYTE: lanes = sel_t'(1) << addr_lo; // Single lane
         default:  lanes = '1;
      endcase
   end

   // Mask is the inverse, so all lanes masked out of reset
   always_ff @(posedge clk) begin
      if (RST_I) begin
         sel   <= '0;
         bmask <= '1;
      end else if (sa41) begin
         sel   <= lanes;
         bmask <= ~lanes;
      end
   end

endmodule

// ==== bus_cycle/bus_strobe.sv ====
// Bus strobe generator
// Raises the I/O or the SRAM strobe one cycle after the microcode asks for
// an access, and holds it until the matching acknowledge

`timescale 1ns/1ps

`include "progress_config.svh"

module bus_strobe
   import bus_pkg::*;
(
   input  logic                  clk,
   input  logic                  RST_I,
   input  logic                  nobuserror, // Low on a bus error
   input  logic                  sa42,       // Start an access
   input  logic                  sa30,       // Current store is SW
   input  logic                  qack,       // Qualified I/O acknowledge
   input  logic                  sram_ack,
   input  logic [`PC_ADDR_W-1:0] addr,
   output logic                  stb,        // I/O cycle in progress
   output logic                  sram_stb    // SRAM cycle in progress
);

   region_t region;
   logic    misaligned;
   logic    issue_io;
   logic    issue_sram;
   logic    stb_nxt;
   logic    sram_stb_nxt;

   assign region     = addr_region(addr);
   assign misaligned = store_misaligned(sa30, addr); // Misaligned SW gets no strobe

   assign issue_io   = sa42 & (region == REGION_IO) & ~misaligned;
   assign issue_sram = sa42 & (region == REGION_SRAM) & ~misaligned;

   // Set on issue, drop on the edge that sees the acknowledge
   assign stb_nxt      = issue_io | (stb & ~qack);
   assign sram_stb_nxt = issue_sram | (sram_stb & ~sram_ack);

   always_ff @(posedge clk) begin
      if (RST_I || !nobuserror) begin // Bus error aborts both cycles
         stb      <= 1'b0;
         sram_stb <= 1'b0;
      end else begin
         stb      <= stb_nxt;
         sram_stb <= sram_stb_nxt;
      end
   end

endmodule

// ==== bus_cycle/write_enable.sv ====
// Write enable registers
// Bus write enable for SRAM and I/O stores, and the separate enable for
// writes into the control-register region

`timescale 1ns/1ps

`include "progress_config.svh"

module write_enable
   import bus_pkg::*;
(
   input  logic                  clk,
   input  logic                  RST_I,
   input  logic                  nobuserror,
   input  logic                  sa43,       // Load the enables
   input  logic                  sa14,       // End of the store, clear them
   input  logic                  sa30,       // Current store is SW
   input  logic [`PC_ADDR_W-1:0] addr,
   output logic                  we,
   output logic                  ctrlreg_we
);

   region_t region;
   logic    misaligned;
   logic    we_nxt;
   logic    ctrlreg_we_nxt;

   assign region     = addr_region(addr);
   assign misaligned = store_misaligned(sa30, addr);

   assign we_nxt         = ((region == REGION_SRAM) | (region == REGION_IO)) & ~misaligned;
   assign ctrlreg_we_nxt = (region == REGION_CTRL) & ~misaligned;

   always_ff @(posedge clk) begin
      if (sa14 || RST_I || !nobuserror) begin
         we         <= 1'b0;
         ctrlreg_we <= 1'b0;
      end else if (sa43) begin // Only reached with the bus healthy
         we         <= we_nxt;
         ctrlreg_we <= ctrlreg_we_nxt;
      end
   end

endmodule

// ==== bus_cycle/ack_qualify.sv ====
// Acknowledge qualifier
// Combines the slave and system-register acknowledges. A slave that holds
// its acknowledge high outside a cycle is tolerated by falling back on the
// strobe itself until the acknowledge is seen low again

`timescale 1ns/1ps

module ack_qualify (
   input  logic clk,
   input  logic RST_I,
   input  logic ack,       // Raw slave acknowledge
   input  logic sysregack, // System register acknowledge
   input  logic stb,       // I/O strobe
   output logic qack
);

   typedef enum logic {
      ACK_NORMAL = 1'b0,
      ACK_HELD   = 1'b1  // Slave keeps ack high
   } ack_state_t;

   ack_state_t state;
   ack_state_t state_nxt;

   // Ack without a strobe means the slave holds it
   always_comb begin
      case (state)
         ACK_NORMAL: begin
            if (ack && !stb)
               state_nxt = ACK_HELD;
            else
               state_nxt = ACK_NORMAL;
         end
         default: begin
            if (ack)
               state_nxt = ACK_HELD;   // Still held
            else
               state_nxt = ACK_NORMAL; // Slave released it
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (RST_I)
         state <= ACK_NORMAL;
      else
         state <= state_nxt;
   end

   // Held ack carries no information, the strobe stands in for it
   always_comb begin
      if (state == ACK_HELD)
         qack = sysregack | stb;
      else
         qack = sysregack | (ack & stb);
   end

endmodule

// ==== source/ucode_progress.sv ====
// Microcode progress logic
// Decides when the sequencer may advance, when the ALU result is sampled
// and when internal block RAM is written

`timescale 1ns/1ps

module ucode_progress (
   input  logic corerunning,
   input  logic sa15,           // Part of the Q enable
   input  logic sa32,           // Read input
   input  logic sa33,           // Repeat shift until done
   input  logic sa41,           // Select setup cycle
   input  logic lastshift,
   input  logic r_issh0_not,    // Low when a zero shift is inhibited
   input  logic nobuserror,
   input  logic stb,
   input  logic sram_stb,
   input  logic we,
   output logic progress_ucode,
   output logic ena_q,
   output logic iwe
);

   logic pending;    // Any bus cycle waiting for its ack
   logic loop_done;  // Shift loop finished or no repeat asked
   logic avoid_iwe;

   assign pending   = stb | sram_stb;
   assign loop_done = ~sa33 | lastshift | ~r_issh0_not;

   // Waiting on the bus stalls both the sequencer and Q
   assign ena_q = (sa15 | sa32) & ~lastshift & ~pending;

   // Bus error must not leave the microcode stuck
   assign progress_ucode = (loop_done & ~pending) | ~nobuserror;

   assign avoid_iwe = sa41 | we | ~r_issh0_not; // Select setup, bus store, or inhibited shift
   assign iwe       = corerunning & ~avoid_iwe;  // No writes before the core runs

endmodule

// ==== source/progress_ctrl.sv ====
// Progress controller top level
// Turns microcode control bits and the current address into bus strobes,
// write enables and byte selects, and tells the sequencer when to advance

`timescale 1ns/1ps

`include "progress_config.svh"

module progress_ctrl
   import bus_pkg::*;
(
   input  logic                  clk,
   input  logic                  RST_I,
   input  logic                  corerunning,
   input  logic                  ack,            // From I/O slave
   input  logic                  sysregack,
   input  logic                  sram_ack,
   input  logic                  sa14,
   input  logic                  sa15,
   input  logic                  sa24,
   input  logic                  sa25,
   input  logic                  sa26,
   input  logic                  sa27,
   input  logic                  sa30,
   input  logic                  sa32,
   input  logic                  sa33,
   input  logic                  sa41,
   input  logic                  sa42,
   input  logic                  sa43,
   input  logic                  lastshift,
   input  logic                  r_issh0_not,
   input  logic                  nobuserror,
   input  logic [`PC_ADDR_W-1:0] addr,           // Current bus address
   output sel_t                  sel,
   output sel_t                  bmask,
   output logic                  iwe,
   output logic                  ctrlreg_we,
   output logic                  we,
   output logic                  stb,
   output logic                  sram_stb,
   output logic                  ena_q,
   output logic                  progress_ucode,
   output logic                  qack
);

   byte_select u_byte_select (
      .clk, .RST_I, .sa41,
      .sa27, .sa26, .sa25, .sa24,
      .addr_lo (addr[1:0]),
      .sel, .bmask
   );

   // qack loops back into the strobe hold
   bus_strobe u_bus_strobe (
      .clk, .RST_I, .nobuserror,
      .sa42, .sa30,
      .qack, .sram_ack,
      .addr,
      .stb, .sram_stb
   );

   write_enable u_write_enable (
      .clk, .RST_I, .nobuserror,
      .sa43, .sa14, .sa30,
      .addr,
      .we, .ctrlreg_we
   );

   ack_qualify u_ack_qualify (
      .clk, .RST_I,
      .ack, .sysregack, .stb,
      .qack
   );

   ucode_progress u_ucode_progress (
      .corerunning, .sa15, .sa32, .sa33, .sa41,
      .lastshift, .r_issh0_not, .nobuserror,
      .stb, .sram_stb, .we,
      .progress_ucode, .ena_q, .iwe
   );

endmodule

// ==== bench/progress_ctrl_assert.sv ====
// Progress controller assertions
// Bound into the top level, checks strobes, write enables, byte selects,
// acknowledge qualification and the microcode enables, and counts failures

`timescale 1ns/1ps

`include "progress_config.svh"

module progress_ctrl_assert (
   input logic                  clk,
   input logic                  RST_I,
   input logic                  corerunning, ack, sysregack, sram_ack,
   input logic                  sa14, sa15, sa24, sa25, sa26, sa27, sa30,
   input logic                  sa32, sa33, sa41, sa42, sa43,
   input logic                  lastshift, r_issh0_not, nobuserror,
   input logic [`PC_ADDR_W-1:0] addr,
   input logic [`PC_LANES-1:0]  sel, bmask,
   input logic                  iwe, ctrlreg_we, we, stb, sram_stb,
   input logic                  ena_q, progress_ucode, qack
);

   int fail_count = 0; // Read by the testbench at the end

   logic       in_sram, in_io, in_ctrl, aligned;
   logic       issue_io, issue_sram;
   logic       held_ref; // Slave is holding ack outside a cycle
   logic       exp_qack;
   logic [3:0] exp_sel;

   assign in_sram = addr[`PC_REGION_SRAM_BIT]; // SRAM bit overrides the nibble
   assign in_io   = !in_sram && (addr[31:28] == `PC_REGION_IO);
   assign in_ctrl = !in_sram && (addr[31:28] == `PC_REGION_CTRL);
   assign aligned = !(sa30 && (addr[1:0] != 2'b00)); // Only SW has to be aligned

   assign issue_io   = nobuserror && sa42 && in_io && aligned;
   assign issue_sram = nobuserror && sa42 && in_sram && aligned;

   // Halfword at 0 or 2, byte at any offset, else the whole word
   always_comb begin
      if ({sa27, sa26, sa25, sa24} == 4'b0001 && addr[1:0] == 2'b00)
         exp_sel = 4'b0011;
      else if ({sa27, sa26, sa25, sa24} == 4'b0001 && addr[1:0] == 2'b10)
         exp_sel = 4'b1100;
      else if ({sa27, sa26, sa25, sa24} == 4'b0010)
         exp_sel = 4'b0001 << addr[1:0];
      else
         exp_sel = 4'b1111;
   end

   // Held state follows the slave ack
   always_ff @(posedge clk) begin
      if (RST_I)
         held_ref <= 1'b0;
      else
         held_ref <= ack && (held_ref || !stb); // Set without stb, kept while ack stays
   end

   assign exp_qack = sysregack || (stb && (ack || held_ref)); // Stale ack ignored when held

   task automatic report_mismatch(input string what);
      fail_count++;
      $error("mismatch at %0t: %s", $time, what);
   endtask

   a_reset: assert property (@(posedge clk) RST_I |=> sel == '0 && bmask == '1
                             && !stb && !sram_stb && !we && !ctrlreg_we)
      else report_mismatch("outputs not cleared by reset");

   a_sel_load: assert property (@(posedge clk) disable iff (RST_I)
                                sa41 |=> sel == $past(exp_sel))
      else report_mismatch("sel does not follow the lane rule");
   a_bmask: assert property (@(posedge clk) disable iff (RST_I) bmask == ~sel)
      else report_mismatch("bmask is not the inverse of sel");
   a_io_issue: assert property (@(posedge clk) disable iff (RST_I) issue_io |=> stb)
      else report_mismatch("I/O strobe did not rise");
   a_sram_issue: assert property (@(posedge clk) disable iff (RST_I)
                                  issue_sram |=> sram_stb)
      else report_mismatch("SRAM strobe did not rise");
   a_io_rise: assert property (@(posedge clk) disable iff (RST_I)
                               $rose(stb) |-> $past(issue_io))
      else report_mismatch("I/O strobe rose without an aligned request");
   a_sram_rise: assert property (@(posedge clk) disable iff (RST_I)
                                 $rose(sram_stb) |-> $past(issue_sram))
      else report_mismatch("SRAM strobe rose without an aligned request");
   a_io_step: assert property (@(posedge clk) disable iff (RST_I)
                               nobuserror && stb |=> stb == $past(issue_io || !qack))
      else report_mismatch("I/O strobe not held until qack");
   a_sram_step: assert property (@(posedge clk) disable iff (RST_I)
                                 nobuserror && sram_stb
                                 |=> sram_stb == $past(issue_sram || !sram_ack))
      else report_mismatch("SRAM strobe not held until sram_ack");
   a_stall: assert property (@(posedge clk) disable iff (RST_I)
                             nobuserror && (stb || sram_stb) |-> !progress_ucode && !ena_q)
      else report_mismatch("microcode advanced while a strobe waits");
   a_we_load: assert property (@(posedge clk) disable iff (RST_I)
                               sa43 && !sa14 && nobuserror
                               |=> we == $past((in_sram || in_io) && aligned)
                                   && ctrlreg_we == $past(in_ctrl && aligned))
      else report_mismatch("write enables loaded wrongly");
   a_we_clear: assert property (@(posedge clk) disable iff (RST_I)
                                sa14 || !nobuserror |=> !we && !ctrlreg_we)
      else report_mismatch("write enables not cleared");
   a_buserr_stb: assert property (@(posedge clk) disable iff (RST_I)
                                  !nobuserror |=> !stb && !sram_stb)
      else report_mismatch("strobes survive a bus error");
   a_buserr_prog: assert property (@(posedge clk) disable iff (RST_I)
                                   !nobuserror |-> progress_ucode)
      else report_mismatch("progress_ucode low during a bus error");
   a_qack: assert property (@(posedge clk) disable iff (RST_I) qack == exp_qack)
      else report_mismatch("qack differs from the held-ack rule");
   a_progress: assert property (@(posedge clk) disable iff (RST_I)
                                nobuserror && !stb && !sram_stb && (lastshift || !sa33)
                                |-> progress_ucode)
      else report_mismatch("progress_ucode low with the loop done");
   a_ena_q: assert property (@(posedge clk) disable iff (RST_I)
                             ena_q == ((sa15 || sa32) && !lastshift && !stb && !sram_stb))
      else report_mismatch("ena_q wrong");
   a_iwe: assert property (@(posedge clk) disable iff (RST_I)
                           iwe == (corerunning && !sa41 && !we && r_issh0_not))
      else report_mismatch("iwe wrong");

endmodule

bind progress_ctrl progress_ctrl_assert u_assert (.*);

// ==== bench/progress_ctrl_tb.sv ====
// Progress controller testbench
// Walks the DUT through byte selects, strobes, write enables, held acks,
// bus errors and internal writes. The bound assertions judge the results

`timescale 1ns/1ps

`include "progress_config.svh"

module progress_ctrl_tb;

   localparam int TIMEOUT = 40; // Cycles any single wait may take

   logic clk, RST_I, corerunning, ack, sysregack, sram_ack;
   logic sa14, sa15, sa24, sa25, sa26, sa27, sa30, sa32, sa33, sa41, sa42, sa43;
   logic lastshift, r_issh0_not, nobuserror;
   logic [`PC_ADDR_W-1:0] addr;
   logic [`PC_LANES-1:0]  sel, bmask;
   logic iwe, ctrlreg_we, we, stb, sram_stb, ena_q, progress_ucode, qack;

   int tests_run  = 0;
   int timeouts   = 0;
   int fails_seen = 0;

   progress_ctrl UUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic next_cycle(); // Inputs change 1 ns after the edge
      @(posedge clk);
      #1;
   endtask

   task automatic set_idle();
      {corerunning, ack, sysregack, sram_ack} = '0;
      {sa14, sa15, sa24, sa25, sa26, sa27, sa30, sa32, sa33, sa41, sa42, sa43} = '0;
      lastshift   = 1'b0;
      r_issh0_not = 1'b1; // No inhibited zero shift
      nobuserror  = 1'b1;
      addr        = '0;
   endtask

   // Kind 0 SRAM, 1 I/O, 2 control registers, other values unmapped
   function automatic logic [`PC_ADDR_W-1:0] region_address(input int kind, input logic [1:0] lo);
      logic [`PC_ADDR_W-1:0] a;
      a      = $urandom;
      a[1:0] = lo;
      case (kind)
         0:       a[`PC_REGION_SRAM_BIT] = 1'b1;
         1:       a[31:28] = `PC_REGION_IO;
         2:       a[31:28] = `PC_REGION_CTRL;
         default: a[31:28] = 4'h1;
      endcase
      return a;
   endfunction

   task automatic wait_strobe(input bit sram, input bit level, output bit ok);
      ok = 1'b0;
      for (int n = 0; n < TIMEOUT && !ok; n++) begin
         if ((sram ? sram_stb : stb) == level)
            ok = 1'b1;
         else
            next_cycle();
      end
      if (!ok) begin
         timeouts++;
         $display("Timeout at %0t: %s strobe never went to %0d", $time,
                  sram ? "SRAM" : "I/O", level);
      end
   endtask

   // One access, acknowledged after a wait of the given length
   task automatic bus_access(input bit sram, input logic [`PC_ADDR_W-1:0] a, input int delay);
      bit ok;
      addr = a;
      sa42 = 1'b1;
      next_cycle();
      sa42 = 1'b0;
      wait_strobe(sram, 1'b1, ok);
      if (ok) begin
         repeat (delay) next_cycle(); // Back-pressure window
         if (sram)
            sram_ack = 1'b1;
         else
            ack = 1'b1;
         wait_strobe(sram, 1'b0, ok);
         sram_ack = 1'b0;
         ack      = 1'b0;
      end
   endtask

   task automatic finish_test(input string name);
      int now_fails;
      now_fails = UUT.u_assert.fail_count;
      tests_run++;
      $display("Test %0d %s done, %0d new assertion failures", tests_run, name,
               now_fails - fails_seen);
      fails_seen = now_fails;
   endtask

   task automatic test_byte_selects();
      logic [3:0] codes [4] = '{4'b0001, 4'b0010, 4'b0000, 4'b0110};
      foreach (codes[c]) begin
         for (int lo = 0; lo < 4; lo++) begin
            {sa27, sa26, sa25, sa24} = codes[c];
            addr = region_address(3, 2'(lo));
            sa41 = 1'b1;
            next_cycle();
         end
      end
      sa41 = 1'b0;
      next_cycle();
      finish_test("byte selects");
   endtask

   task automatic test_strobes();
      bit ok;
      sa15 = 1'b1; // Q enable requested, the bus wait must still hold it off
      for (int i = 0; i < 8; i++)
         bus_access(i[0], region_address(i[0] ? 0 : 1, 2'b00), $urandom_range(0, 4));
      addr = region_address(1, 2'b00);
      sa42 = 1'b1;
      next_cycle();
      sa42 = 1'b0;
      sysregack = 1'b1; // System register closes the I/O cycle
      wait_strobe(1'b0, 1'b0, ok);
      sysregack = 1'b0;
      sa30 = 1'b1; // SW to an odd address must be refused
      for (int k = 0; k < 2; k++) begin
         addr = region_address(k, 2'($urandom_range(1, 3)));
         sa42 = 1'b1;
         next_cycle();
         sa42 = 1'b0;
         repeat (2) next_cycle();
      end
      sa30 = 1'b0;
      sa15 = 1'b0;
      finish_test("strobe handshake");
   endtask

   task automatic test_write_enables();
      sa30 = 1'b1;
      for (int kind = 0; kind < 4; kind++) begin
         for (int mis = 0; mis < 2; mis++) begin
            addr = region_address(kind, mis ? 2'b10 : 2'b00);
            sa43 = 1'b1;
            next_cycle();
            sa43 = 1'b0;
            sa14 = 1'b1;
            next_cycle();
            sa14 = 1'b0;
         end
      end
      sa30 = 1'b0;
      next_cycle();
      finish_test("write enables");
   endtask

   task automatic test_held_ack();
      bit ok;
      ack = 1'b1; // Slave raises ack with no cycle open
      repeat (2) next_cycle();
      addr = region_address(1, 2'b00);
      sa42 = 1'b1;
      next_cycle();
      sa42 = 1'b0;
      wait_strobe(1'b0, 1'b0, ok); // Strobe acked as it rises
      ack = 1'b0;
      next_cycle();
      bus_access(1'b0, region_address(1, 2'b00), 3); // Normal rule again
      next_cycle();
      finish_test("held acknowledge");
   endtask

   task automatic test_bus_error();
      bit ok;
      addr = region_address(1, 2'b00);
      sa42 = 1'b1;
      next_cycle();
      addr = region_address(0, 2'b00); // SRAM access and store on top
      sa43 = 1'b1;
      next_cycle();
      {sa42, sa43} = 2'b00;
      wait_strobe(1'b1, 1'b1, ok);
      nobuserror = 1'b0;
      next_cycle();
      nobuserror = 1'b1;
      next_cycle();
      finish_test("bus error");
   endtask

   task automatic test_internal_write();
      logic [31:0] r;
      for (int phase = 0; phase < 2; phase++) begin
         if (phase == 1) begin // Second pass with we set
            addr = region_address(0, 2'b00);
            sa43 = 1'b1;
            next_cycle();
            sa43 = 1'b0;
         end
         for (int i = 0; i < 8; i++) begin
            r = $urandom;
            {corerunning, sa41, r_issh0_not} = 3'(i);
            {sa15, sa32, sa33, lastshift} = r[3:0];
            next_cycle();
         end
      end
      set_idle();
      sa14 = 1'b1;
      next_cycle();
      sa14 = 1'b0;
      finish_test("internal write");
   endtask

   initial begin
      void'($urandom(46090)); // Seed for addresses and ack delays
      set_idle();
      RST_I = 1'b1;
      repeat (2) next_cycle();
      RST_I = 1'b0;
      next_cycle();
      test_byte_selects();
      test_strobes();
      test_write_enables();
      test_held_ack();
      test_bus_error();
      test_internal_write();
      $display("Tests run %0d, assertion failures %0d, timeouts %0d", tests_run,
               UUT.u_assert.fail_count, timeouts);
      if (UUT.u_assert.fail_count == 0 && timeouts == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// ==== Bender.yml ====
package:
  name: progress_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/bus_pkg.sv
      - common/ucode_pkg.sv
      - source/byte_select.sv
      - bus_cycle/bus_strobe.sv
      - bus_cycle/write_enable.sv
      - bus_cycle/ack_qualify.sv
      - source/ucode_progress.sv
      - source/progress_ctrl.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/progress_ctrl_assert.sv
      - bench/progress_ctrl_tb.sv

// ==== vlog.f ====
+incdir+common
common/bus_pkg.sv
common/ucode_pkg.sv
source/byte_select.sv
bus_cycle/bus_strobe.sv
bus_cycle/write_enable.sv
bus_cycle/ack_qualify.sv
source/ucode_progress.sv
source/progress_ctrl.sv
bench/progress_ctrl_assert.sv
bench/progress_ctrl_tb.sv
